/* logic/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

	localparam int xlen     = 32;
	localparam int imm_w    = 16; // I-type immediate field
	localparam int target_w = 26; // J-type index field

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0]      reg_addr_t;
	typedef logic [5:0]      opcode_t;
	typedef logic [5:0]      funct_t;

	// primary opcodes
	localparam opcode_t op_special = 6'h00;
	localparam opcode_t op_j       = 6'h02;
	localparam opcode_t op_jal     = 6'h03;
	localparam opcode_t op_beq     = 6'h04;
	localparam opcode_t op_bne     = 6'h05;
	localparam opcode_t op_addiu   = 6'h09;
	localparam opcode_t op_slti    = 6'h0a;
	localparam opcode_t op_sltiu   = 6'h0b;
	localparam opcode_t op_andi    = 6'h0c;
	localparam opcode_t op_ori     = 6'h0d;
	localparam opcode_t op_xori    = 6'h0e;
	localparam opcode_t op_lui     = 6'h0f;
	localparam opcode_t op_lw      = 6'h23;
	localparam opcode_t op_sw      = 6'h2b;

	// function codes under op_special
	localparam funct_t fn_jr   = 6'h08;
	localparam funct_t fn_jalr = 6'h09;
	localparam funct_t fn_addu = 6'h21;
	localparam funct_t fn_subu = 6'h23;
	localparam funct_t fn_and  = 6'h24;
	localparam funct_t fn_or   = 6'h25;
	localparam funct_t fn_xor  = 6'h26;
	localparam funct_t fn_nor  = 6'h27;
	localparam funct_t fn_slt  = 6'h2a;
	localparam funct_t fn_sltu = 6'h2b;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_slt, alu_sltu
	} alu_op_t;

	localparam reg_addr_t link_reg = 5'd31; // jal destination
	localparam word_t     reset_pc = 32'h0000_0000;
	localparam word_t     pc_step  = 32'd4;

endpackage

`default_nettype wire

/* logic/cpu_bus_pkg.sv */
`default_nettype none

package cpu_bus_pkg;

	// one-hot controller states
	typedef enum logic [8:0] {
		st_init  = 9'b0_0000_0001,
		st_if    = 9'b0_0000_0010,
		st_iw    = 9'b0_0000_0100,
		st_id    = 9'b0_0000_1000,
		st_ex    = 9'b0_0001_0000,
		st_store = 9'b0_0010_0000,
		st_load  = 9'b0_0100_0000,
		st_rdw   = 9'b0_1000_0000,
		st_wb    = 9'b1_0000_0000
	} cpu_state_t;

	typedef struct packed {
		cpu_isa_pkg::word_t addr;
		cpu_isa_pkg::word_t wdata;
		logic [3:0]         wstrb;
		logic               read;
		logic               write;
	} mem_req_t;

	// wen in the top bit, pc in the low word
	typedef struct packed {
		logic                   wen;
		cpu_isa_pkg::reg_addr_t waddr;
		cpu_isa_pkg::word_t     wdata;
		cpu_isa_pkg::word_t     pc;
	} retire_t;

	typedef struct packed {
		cpu_isa_pkg::alu_op_t alu_op;
		logic use_imm;   // b operand from immediate
		logic zero_ext;  // logical immediates
		logic is_lui;
		logic is_load;
		logic is_store;
		logic is_branch;
		logic branch_ne; // set for bne
		logic is_jump;
		logic jump_reg;  // jr and jalr
		logic link;
		logic writes_rd;
		logic writes_rt;
	} ctrl_t;

endpackage

`default_nettype wire

/* logic/cpu_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_decode (
	input  cpu_isa_pkg::word_t                  ir,
	output cpu_bus_pkg::ctrl_t                  ctrl,
	output cpu_isa_pkg::reg_addr_t              rs,
	output cpu_isa_pkg::reg_addr_t              rt,
	output cpu_isa_pkg::reg_addr_t              rd,
	output logic [cpu_isa_pkg::imm_w-1:0]       imm,
	output logic [cpu_isa_pkg::target_w-1:0]    target,
	output logic                                nop
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	opcode_t opcode;
	funct_t  funct;

	assign opcode = ir[31:26];
	assign rs     = ir[25:21];
	assign rt     = ir[20:16];
	assign rd     = ir[15:11];
	assign funct  = ir[5:0];
	assign imm    = ir[imm_w-1:0];
	assign target = ir[target_w-1:0];
	assign nop    = (ir == '0); // all-zero word only

	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = alu_add;
		case (opcode)
			op_special: begin
				ctrl.writes_rd = 1'b1;
				case (funct)
					fn_jr: begin
						ctrl.writes_rd = 1'b0;
						ctrl.is_jump   = 1'b1;
						ctrl.jump_reg  = 1'b1;
					end
					fn_jalr: begin
						ctrl.is_jump  = 1'b1;
						ctrl.jump_reg = 1'b1;
						ctrl.link     = 1'b1;
					end
					fn_addu: ctrl.alu_op = alu_add;
					fn_subu: ctrl.alu_op = alu_sub;
					fn_and:  ctrl.alu_op = alu_and;
					fn_or:   ctrl.alu_op = alu_or;
					fn_xor:  ctrl.alu_op = alu_xor;
					fn_nor:  ctrl.alu_op = alu_nor;
					fn_slt:  ctrl.alu_op = alu_slt;
					fn_sltu: ctrl.alu_op = alu_sltu;
					default: ctrl.writes_rd = 1'b0; // unsupported funct retires nothing
				endcase
			end
			op_j:   ctrl.is_jump = 1'b1;
			op_jal: begin
				ctrl.is_jump = 1'b1;
				ctrl.link    = 1'b1;
			end
			op_beq, op_bne: begin
				ctrl.is_branch = 1'b1;
				ctrl.branch_ne = (opcode == op_bne);
				ctrl.alu_op    = alu_sub; // compare through the zero flag
			end
			op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori: begin
				ctrl.use_imm   = 1'b1;
				ctrl.writes_rt = 1'b1;
				case (opcode)
					op_slti:  ctrl.alu_op = alu_slt;
					op_sltiu: ctrl.alu_op = alu_sltu; // sign-extended, compared unsigned
					op_andi:  ctrl.alu_op = alu_and;
					op_ori:   ctrl.alu_op = alu_or;
					op_xori:  ctrl.alu_op = alu_xor;
					default:  ctrl.alu_op = alu_add;
				endcase
				ctrl.zero_ext = (opcode == op_andi) || (opcode == op_ori) || (opcode == op_xori);
			end
			op_lui: begin
				ctrl.is_lui    = 1'b1;
				ctrl.writes_rt = 1'b1;
			end
			op_lw: begin
				ctrl.is_load   = 1'b1;
				ctrl.use_imm   = 1'b1;
				ctrl.writes_rt = 1'b1;
			end
			op_sw: begin
				ctrl.is_store = 1'b1;
				ctrl.use_imm  = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

/* logic/cpu_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_alu (
	input  cpu_isa_pkg::word_t   a,
	input  cpu_isa_pkg::word_t   b,
	input  cpu_isa_pkg::alu_op_t op,
	output cpu_isa_pkg::word_t   result,
	output logic                 zero
);
	import cpu_isa_pkg::*;

	always_comb begin
		case (op)
			alu_add:  result = a + b;
			alu_sub:  result = a - b;
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_xor:  result = a ^ b;
			alu_nor:  result = ~(a | b);
			alu_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
			default:  result = '0;
		endcase
	end

	assign zero = (result == '0); // beq/bne use this on a - b

endmodule

`default_nettype wire

/* logic/cpu_reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_reg_file (
	input  logic                   clk,
	input  cpu_isa_pkg::reg_addr_t raddr1,
	input  cpu_isa_pkg::reg_addr_t raddr2,
	output cpu_isa_pkg::word_t     rdata1,
	output cpu_isa_pkg::word_t     rdata2,
	input  logic                   wen,
	input  cpu_isa_pkg::reg_addr_t waddr,
	input  cpu_isa_pkg::word_t     wdata
);
	import cpu_isa_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (wen && (waddr != '0))
			regs[waddr] <= wdata; // writes to r0 are dropped
	end

	// r0 is hardwired
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* logic/cpu_control_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_control_fsm (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    is_load,
	input  logic                    is_store,
	input  logic                    wb_needed,
	input  logic                    nop,
	input  logic                    inst_req_ready,
	input  logic                    inst_valid,
	input  logic                    mem_req_ready,
	input  logic                    read_data_valid,
	output cpu_bus_pkg::cpu_state_t state,
	output logic                    inst_req_valid,
	output logic                    inst_ready,
	output logic                    mem_read,
	output logic                    mem_write,
	output logic                    read_data_ready
);
	import cpu_bus_pkg::*;

	cpu_state_t next_state;

	always_ff @(posedge clk) begin
		if (rst)
			state <= st_init;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state; // hold while waiting on a handshake
		case (state)
			st_init: next_state = st_if;
			st_if: begin
				if (inst_req_ready)
					next_state = st_iw;
			end
			st_iw: begin
				if (inst_valid)
					next_state = st_id;
			end
			st_id:   next_state = nop ? st_if : st_ex;
			st_ex: begin
				// loads also write back, so check them before wb_needed
				if (is_store)
					next_state = st_store;
				else if (is_load)
					next_state = st_load;
				else if (wb_needed)
					next_state = st_wb;
				else
					next_state = st_if; // branches, j, jr
			end
			st_store: begin
				if (mem_req_ready)
					next_state = st_if;
			end
			st_load: begin
				if (mem_req_ready)
					next_state = st_rdw;
			end
			st_rdw: begin
				if (read_data_valid)
					next_state = st_wb;
			end
			st_wb:   next_state = st_if;
			default: next_state = st_init;
		endcase
	end

	// strobes straight from the state register
	assign inst_req_valid  = (state == st_if);
	assign inst_ready      = (state == st_iw);
	assign mem_write       = (state == st_store);
	assign mem_read        = (state == st_load);
	assign read_data_ready = (state == st_rdw);

endmodule

`default_nettype wire

/* logic/cpu_datapath.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_datapath (
	input  logic                    clk,
	input  logic                    rst,
	input  cpu_bus_pkg::cpu_state_t state,
	input  logic                    inst_valid,
	input  cpu_isa_pkg::word_t      instruction,
	input  logic                    read_data_valid,
	input  cpu_isa_pkg::word_t      read_data,
	input  logic                    mem_write,
	input  logic                    mem_read,
	output cpu_isa_pkg::word_t      pc,
	output cpu_bus_pkg::mem_req_t   mem_req,
	output cpu_bus_pkg::retire_t    retire,
	output logic                    is_load,
	output logic                    is_store,
	output logic                    wb_needed,
	output logic                    nop
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	word_t               ir;
	word_t               mdr;
	word_t               alu_out;
	word_t               retired_pc; // address of the instruction in flight
	ctrl_t               ctrl;
	reg_addr_t           rs;
	reg_addr_t           rt;
	reg_addr_t           rd;
	reg_addr_t           waddr;
	logic [imm_w-1:0]    imm;
	logic [target_w-1:0] target;
	word_t               rdata1;
	word_t               rdata2;
	word_t               imm_ext;
	word_t               branch_off;
	word_t               alu_a;
	word_t               alu_b;
	word_t               alu_result;
	word_t               wb_data;
	alu_op_t             alu_op;
	logic                alu_zero;
	logic                branch_taken;
	logic                ir_load;
	logic                rf_wen;

	cpu_decode u_decode (
		.ir(ir), .ctrl(ctrl), .rs(rs), .rt(rt), .rd(rd),
		.imm(imm), .target(target), .nop(nop)
	);

	assign imm_ext    = ctrl.zero_ext ? {{(xlen-imm_w){1'b0}}, imm}
	                                  : {{(xlen-imm_w){imm[imm_w-1]}}, imm};
	assign branch_off = {{(xlen-imm_w-2){imm[imm_w-1]}}, imm, 2'b00};

	// IW: pc+4, ID: branch target, EX: the instruction itself
	always_comb begin
		alu_a  = rdata1;
		alu_b  = ctrl.use_imm ? imm_ext : rdata2;
		alu_op = ctrl.alu_op;
		if (state == st_iw) begin
			alu_a  = pc;
			alu_b  = pc_step;
			alu_op = alu_add;
		end else if (state == st_id) begin
			alu_a  = pc; // already address + 4 here
			alu_b  = branch_off;
			alu_op = alu_add;
		end else if (ctrl.link) begin
			alu_a  = pc; // link = address + 8
			alu_b  = pc_step;
			alu_op = alu_add;
		end
	end

	cpu_alu u_alu (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result), .zero(alu_zero));

	assign branch_taken = ctrl.is_branch && (alu_zero ^ ctrl.branch_ne);
	assign ir_load      = (state == st_iw) && inst_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc         <= reset_pc;
			retired_pc <= reset_pc;
		end else if (ir_load) begin
			pc         <= alu_result;
			retired_pc <= pc;
		end else if (state == st_ex) begin
			if (ctrl.is_jump && ctrl.jump_reg)
				pc <= rdata1;
			else if (ctrl.is_jump)
				pc <= {pc[31:28], target, 2'b00};
			else if (branch_taken)
				pc <= alu_out; // target computed in ID
		end
	end

	always_ff @(posedge clk) begin
		if (ir_load)
			ir <= instruction;
		if ((state == st_id) || (state == st_ex))
			alu_out <= alu_result;
		if ((state == st_rdw) && read_data_valid)
			mdr <= read_data;
	end

	assign waddr   = ctrl.writes_rt ? rt : (ctrl.writes_rd ? rd : link_reg);
	assign wb_data = ctrl.is_load ? mdr :
	                 ctrl.is_lui  ? {imm, {(xlen-imm_w){1'b0}}} : alu_out;
	assign rf_wen  = (state == st_wb);

	cpu_reg_file u_reg_file (
		.clk(clk), .raddr1(rs), .raddr2(rt), .rdata1(rdata1), .rdata2(rdata2),
		.wen(rf_wen), .waddr(waddr), .wdata(wb_data)
	);

	// word-aligned, full-word stores only
	assign mem_req = '{addr:  {alu_out[xlen-1:2], 2'b00},
	                   wdata: rdata2,
	                   wstrb: mem_write ? 4'b1111 : 4'b0000,
	                   read:  mem_read,
	                   write: mem_write};

	assign retire = '{wen: rf_wen, waddr: waddr, wdata: wb_data, pc: retired_pc};

	assign is_load   = ctrl.is_load;
	assign is_store  = ctrl.is_store;
	assign wb_needed = ctrl.writes_rd || ctrl.writes_rt || ctrl.link;

endmodule

`default_nettype wire

/* logic/cpu_core.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_core (
	input  logic                  clk,
	input  logic                  rst,
	output cpu_isa_pkg::word_t    pc,
	output logic                  inst_req_valid,
	input  logic                  inst_req_ready,
	input  cpu_isa_pkg::word_t    instruction,
	input  logic                  inst_valid,
	output logic                  inst_ready,
	output cpu_bus_pkg::mem_req_t mem_req,
	input  logic                  mem_req_ready,
	input  cpu_isa_pkg::word_t    read_data,
	input  logic                  read_data_valid,
	output logic                  read_data_ready,
	output cpu_bus_pkg::retire_t  retire
);
	import cpu_bus_pkg::*;

	cpu_state_t state;
	logic       mem_read;
	logic       mem_write;
	logic       is_load;
	logic       is_store;
	logic       wb_needed;
	logic       nop;

	cpu_control_fsm u_control_fsm (
		.clk(clk), .rst(rst),
		.is_load(is_load), .is_store(is_store), .wb_needed(wb_needed), .nop(nop),
		.inst_req_ready(inst_req_ready), .inst_valid(inst_valid),
		.mem_req_ready(mem_req_ready), .read_data_valid(read_data_valid),
		.state(state),
		.inst_req_valid(inst_req_valid), .inst_ready(inst_ready),
		.mem_read(mem_read), .mem_write(mem_write), .read_data_ready(read_data_ready)
	);

	cpu_datapath u_datapath (
		.clk(clk), .rst(rst), .state(state),
		.inst_valid(inst_valid), .instruction(instruction),
		.read_data_valid(read_data_valid), .read_data(read_data),
		.mem_write(mem_write), .mem_read(mem_read),
		.pc(pc), .mem_req(mem_req), .retire(retire),
		.is_load(is_load), .is_store(is_store), .wb_needed(wb_needed), .nop(nop)
	);

endmodule

`default_nettype wire

/* dv/cpu_core_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_core_asserts (
	input logic                  clk,
	input logic                  rst,
	input cpu_isa_pkg::word_t    pc,
	input logic                  inst_req_valid,
	input logic                  inst_req_ready,
	input cpu_bus_pkg::mem_req_t mem_req,
	input logic                  mem_req_ready,
	input cpu_bus_pkg::retire_t  retire
);
	int unsigned failures = 0; // polled by the testbench

	rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(mem_req.read && mem_req.write))
	else begin
		failures++;
		$error("data read and write requested together");
	end

	one_channel: assert property (@(posedge clk) disable iff (rst)
		!(inst_req_valid && (mem_req.read || mem_req.write)))
	else begin
		failures++;
		$error("fetch and data request active together");
	end

	retire_aligned: assert property (@(posedge clk) disable iff (rst)
		retire.pc[1:0] == 2'b00)
	else begin
		failures++;
		$error("retire pc not word aligned");
	end

	// held requests keep address and payload
	fetch_held: assert property (@(posedge clk) disable iff (rst)
		inst_req_valid && !inst_req_ready |=> inst_req_valid && $stable(pc))
	else begin
		failures++;
		$error("fetch request changed before it was accepted");
	end

	data_held: assert property (@(posedge clk) disable iff (rst)
		(mem_req.read || mem_req.write) && !mem_req_ready |=> $stable(mem_req))
	else begin
		failures++;
		$error("data request changed before it was accepted");
	end

endmodule

bind cpu_core cpu_core_asserts u_cpu_core_asserts (
	.clk(clk), .rst(rst), .pc(pc),
	.inst_req_valid(inst_req_valid), .inst_req_ready(inst_req_ready),
	.mem_req(mem_req), .mem_req_ready(mem_req_ready), .retire(retire)
);

`default_nettype wire

/* dv/cpu_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpu_core_tb;
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	localparam int timeout_cycles = 40;

	typedef enum logic [1:0] {ev_none, ev_retire, ev_store} ev_kind_t;

	// one executed instruction in program order
	typedef struct packed {
		word_t    pc;    // expected fetch address
		word_t    inst;
		ev_kind_t kind;
		word_t    where; // waddr or store address
		word_t    value;
	} step_t;

	logic     clk;
	logic     rst;
	word_t    pc;
	logic     inst_req_valid;
	logic     inst_req_ready;
	word_t    instruction;
	logic     inst_valid;
	logic     inst_ready;
	mem_req_t mem_req;
	logic     mem_req_ready;
	word_t    read_data;
	logic     read_data_valid;
	logic     read_data_ready;
	retire_t  retire;

	word_t       mem [256]; // word addressed by byte address bits 9:2
	step_t       trace [$];
	logic [31:0] rng_state = 32'd78640;

	cpu_core u_cpu_core (
		.clk(clk), .rst(rst), .pc(pc),
		.inst_req_valid(inst_req_valid), .inst_req_ready(inst_req_ready),
		.instruction(instruction), .inst_valid(inst_valid), .inst_ready(inst_ready),
		.mem_req(mem_req), .mem_req_ready(mem_req_ready),
		.read_data(read_data), .read_data_valid(read_data_valid),
		.read_data_ready(read_data_ready), .retire(retire)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic int next_delay(); // 0 to 3 cycles
		rng_state = xorshift32(rng_state);
		return int'(rng_state[1:0]);
	endfunction

	function automatic word_t r_type(input funct_t fn, input reg_addr_t rs, input reg_addr_t rt,
			input reg_addr_t rd);
		return {op_special, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t i_type(input opcode_t op, input reg_addr_t rs, input reg_addr_t rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_type(input opcode_t op, input word_t dest);
		return {op, dest[27:2]};
	endfunction

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		abort_run();
	endtask

	task automatic check(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic drive_edge(); // next rising edge plus drive skew
		@(posedge clk);
		#2;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) drive_edge();
	endtask

	task automatic add_step(input word_t addr, input word_t inst, input ev_kind_t kind,
			input word_t where, input word_t value);
		step_t s;
		s = '{addr, inst, kind, where, value};
		trace.push_back(s);
		mem[addr[9:2]] = inst;
	endtask

	task automatic load_program();
		for (int i = 0; i < 256; i++)
			mem[i] = 32'hfc00_0000 | 32'(i * 4);
		// alu, immediates and lui
		add_step(32'h000, i_type(op_lui, 5'd0, 5'd1, 16'h1234), ev_retire, 32'd1, 32'h1234_0000);
		add_step(32'h004, i_type(op_ori, 5'd1, 5'd1, 16'h5678), ev_retire, 32'd1, 32'h1234_5678);
		add_step(32'h008, i_type(op_addiu, 5'd0, 5'd2, 16'hfffd), ev_retire, 32'd2, 32'hffff_fffd);
		add_step(32'h00c, i_type(op_addiu, 5'd0, 5'd3, 16'h0005), ev_retire, 32'd3, 32'h0000_0005);
		add_step(32'h010, r_type(fn_addu, 5'd1, 5'd3, 5'd4), ev_retire, 32'd4, 32'h1234_567d);
		add_step(32'h014, r_type(fn_subu, 5'd3, 5'd2, 5'd5), ev_retire, 32'd5, 32'h0000_0008);
		add_step(32'h018, r_type(fn_and, 5'd2, 5'd5, 5'd6), ev_retire, 32'd6, 32'h0000_0008);
		add_step(32'h01c, r_type(fn_or, 5'd5, 5'd3, 5'd7), ev_retire, 32'd7, 32'h0000_000d);
		add_step(32'h020, r_type(fn_xor, 5'd1, 5'd2, 5'd8), ev_retire, 32'd8, 32'hedcb_a985);
		add_step(32'h024, r_type(fn_nor, 5'd3, 5'd0, 5'd9), ev_retire, 32'd9, 32'hffff_fffa);
		add_step(32'h028, r_type(fn_slt, 5'd2, 5'd3, 5'd10), ev_retire, 32'd10, 32'h0000_0001);
		add_step(32'h02c, r_type(fn_sltu, 5'd2, 5'd3, 5'd11), ev_retire, 32'd11, 32'h0000_0000);
		add_step(32'h030, i_type(op_slti, 5'd2, 5'd12, 16'h0000), ev_retire, 32'd12, 32'h1);
		add_step(32'h034, i_type(op_sltiu, 5'd3, 5'd13, 16'hffff), ev_retire, 32'd13, 32'h1);
		add_step(32'h038, i_type(op_andi, 5'd2, 5'd14, 16'hff0f), ev_retire, 32'd14, 32'h0000_ff0d);
		add_step(32'h03c, i_type(op_xori, 5'd3, 5'd15, 16'h8000), ev_retire, 32'd15, 32'h0000_8005);
		add_step(32'h040, i_type(op_addiu, 5'd0, 5'd16, 16'h0200), ev_retire, 32'd16, 32'h200);
		// stores and loads back from the same words
		add_step(32'h044, i_type(op_sw, 5'd16, 5'd1, 16'h0004), ev_store, 32'h204, 32'h1234_5678);
		add_step(32'h048, i_type(op_sw, 5'd16, 5'd9, 16'hfffc), ev_store, 32'h1fc, 32'hffff_fffa);
		add_step(32'h04c, i_type(op_lw, 5'd16, 5'd17, 16'h0004), ev_retire, 32'd17, 32'h1234_5678);
		add_step(32'h050, i_type(op_lw, 5'd16, 5'd18, 16'hfffc), ev_retire, 32'd18, 32'hffff_fffa);
		// taken and untaken branches checked by the next fetch address
		add_step(32'h054, i_type(op_beq, 5'd17, 5'd1, 16'h0002), ev_none, 32'd0, 32'd0);
		add_step(32'h060, i_type(op_bne, 5'd17, 5'd1, 16'h0005), ev_none, 32'd0, 32'd0);
		add_step(32'h064, i_type(op_bne, 5'd3, 5'd2, 16'h0002), ev_none, 32'd0, 32'd0);
		add_step(32'h070, i_type(op_beq, 5'd3, 5'd2, 16'hfff0), ev_none, 32'd0, 32'd0);
		add_step(32'h074, 32'h0000_0000, ev_none, 32'd0, 32'd0);
		// jumps and links with link address + 8
		add_step(32'h078, j_type(op_jal, 32'h0a0), ev_retire, 32'd31, 32'h080);
		add_step(32'h0a0, i_type(op_addiu, 5'd0, 5'd19, 16'h00c0), ev_retire, 32'd19, 32'h0c0);
		add_step(32'h0a4, r_type(fn_jalr, 5'd19, 5'd0, 5'd20), ev_retire, 32'd20, 32'h0ac);
		add_step(32'h0c0, r_type(fn_jr, 5'd31, 5'd0, 5'd0), ev_none, 32'd0, 32'd0);
		add_step(32'h080, j_type(op_j, 32'h100), ev_none, 32'd0, 32'd0);
		add_step(32'h100, j_type(op_j, 32'h100), ev_none, 32'd0, 32'd0);
		add_step(32'h100, j_type(op_j, 32'h100), ev_none, 32'd0, 32'd0); // self loop
	endtask

	task automatic serve_fetch();
		word_t addr;
		int    n;
		addr = pc;
		n = 0;
		idle(next_delay());
		drive_edge();
		inst_req_ready = 1'b1;
		drive_edge(); // accepted at this edge
		inst_req_ready = 1'b0;
		idle(next_delay());
		instruction = mem[addr[9:2]];
		inst_valid  = 1'b1;
		@(negedge clk);
		while (!inst_ready) begin
			n++;
			if (n > timeout_cycles)
				report_failure("timeout: core never raised inst_ready");
			@(negedge clk);
		end
		drive_edge();
		inst_valid = 1'b0;
	endtask

	task automatic serve_data();
		mem_req_t req;
		int       n;
		req = mem_req;
		n = 0;
		idle(next_delay());
		drive_edge();
		mem_req_ready = 1'b1;
		drive_edge();
		mem_req_ready = 1'b0;
		if (req.write) begin
			mem[req.addr[9:2]] = req.wdata;
		end else begin
			idle(next_delay());
			read_data       = mem[req.addr[9:2]];
			read_data_valid = 1'b1;
			@(negedge clk);
			while (!read_data_ready) begin
				n++;
				if (n > timeout_cycles)
					report_failure("timeout: core never raised read_data_ready");
				@(negedge clk);
			end
			drive_edge();
			read_data_valid = 1'b0;
		end
	endtask

	// decisions at the falling edge where core outputs are settled
	initial begin : memory_model
		forever begin
			@(negedge clk);
			if (inst_req_valid === 1'b1)
				serve_fetch();
			else if (mem_req.read === 1'b1 || mem_req.write === 1'b1)
				serve_data();
		end
	end

	initial begin : assertion_watch
		forever begin
			@(negedge clk);
			if (u_cpu_core.u_cpu_core_asserts.failures != 0)
				report_failure("a protocol assertion on the core ports failed");
		end
	end

	task automatic check_idle(input string when);
		check(32'(inst_req_valid), 32'd0, {"inst_req_valid ", when});
		check(32'(inst_ready), 32'd0, {"inst_ready ", when});
		check(32'(mem_req.read), 32'd0, {"mem_req.read ", when});
		check(32'(mem_req.write), 32'd0, {"mem_req.write ", when});
		check(32'(read_data_ready), 32'd0, {"read_data_ready ", when});
		check(32'(retire.wen), 32'd0, {"retire.wen ", when});
	endtask

	task automatic wait_fetch(input word_t exp_pc);
		int n;
		n = 0;
		@(negedge clk);
		while (!(inst_req_valid && inst_req_ready)) begin
			if (retire.wen === 1'b1 || (mem_req.write && mem_req_ready))
				report_failure("unexpected retire or store before the next fetch");
			n++;
			if (n > timeout_cycles)
				report_failure("timeout: no instruction fetch was accepted");
			@(negedge clk);
		end
		check(pc, exp_pc, "fetch address");
	endtask

	task automatic expect_event(input step_t s);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > timeout_cycles)
				report_failure("timeout: no retire record or store request seen");
		end while (s.kind == ev_retire ? !retire.wen : !(mem_req.write && mem_req_ready));
		if (s.kind == ev_retire) begin
			check(32'(retire.waddr), s.where, "retire waddr");
			check(retire.wdata, s.value, "retire wdata");
			check(retire.pc, s.pc, "retire pc");
		end else begin
			check(mem_req.addr, s.where, "store address");
			check(mem_req.wdata, s.value, "store data");
			check(32'(mem_req.wstrb), 32'hf, "store strobes");
		end
	endtask

	initial begin : main
		rst             = 1'b1;
		inst_req_ready  = 1'b0;
		instruction     = '0;
		inst_valid      = 1'b0;
		mem_req_ready   = 1'b0;
		read_data       = '0;
		read_data_valid = 1'b0;
		load_program();
		@(posedge clk);
		@(negedge clk);
		check_idle("during reset");
		drive_edge(); // second reset edge
		rst = 1'b0;
		@(negedge clk);
		check_idle("after reset");
		foreach (trace[i]) begin
			wait_fetch(trace[i].pc);
			if (trace[i].kind != ev_none)
				expect_event(trace[i]);
		end
		if (u_cpu_core.u_cpu_core_asserts.failures == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			report_failure("protocol assertions failed during the run");
		end
	end

endmodule

`default_nettype wire

/* all.f */
logic/cpu_isa_pkg.sv
logic/cpu_bus_pkg.sv
logic/cpu_decode.sv
logic/cpu_alu.sv
logic/cpu_reg_file.sv
logic/cpu_control_fsm.sv
logic/cpu_datapath.sv
logic/cpu_core.sv
dv/cpu_core_asserts.sv
dv/cpu_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_core_tb
FILELIST  ?= all.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test FAILED, run did not finish"; exit 1; fi
	@echo "test PASSED"

clean:
	rm -rf $(BUILD_DIR)
